/* common/sap_macros.svh */
`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

// Word and address widths
`define SAP_DATA_W 8
`define SAP_ADDR_W 4
`define SAP_MEM_DEPTH 16

// Operand locations used by the ADD and SUB programs
`define SAP_ADDR_B 14
`define SAP_ADDR_A 15

// Status frame
`define SAP_SPI_FRAME_W 40
`define SAP_SPI_CLK_DIV 4 // clk cycles per sclk half period

`endif

/* common/cpu_pkg.sv */
`include "sap_macros.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_LDA = 4'h0,
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_SNG = 4'h3,
        OP_OUT = 4'hE,
        OP_HLT = 4'hF
    } opcode_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`SAP_ADDR_W-1:0] operand;
    } instr_t;

    // IR sees an instruction, A and B see a byte
    typedef union packed {
        instr_t                 instr;
        logic [`SAP_DATA_W-1:0] data;
    } mem_word_u;

    typedef enum logic [2:0] {T0, T1, T2, T3, T4, T5} step_t;

    typedef struct packed {
        logic pc_inc;
        logic pc_en;    // PC drives bus
        logic mar_load;
        logic mem_en;   // Memory drives bus
        logic ir_load;
        logic ir_en;    // IR operand drives bus
        logic a_load;
        logic b_load;
        logic alu_sub;
        logic alu_en;   // Adder drives bus
        logic acc_load;
        logic out_load;
        logic sng_en;
    } ctrl_word_t;

endpackage

/* common/io_pkg.sv */
`include "sap_macros.svh"

package io_pkg;

    typedef enum logic [1:0] {PROG_ADD, PROG_SUB, PROG_SNG} prog_sel_e;

    typedef struct packed {
        prog_sel_e              prog_sel;
        logic [`SAP_DATA_W-1:0] operand_a;
        logic [`SAP_DATA_W-1:0] operand_b;
        logic [3:0]             song;
    } host_cmd_t;

    typedef struct packed {
        logic [`SAP_DATA_W-1:0] value;
        logic                   overflow;
        logic                   underflow;
    } run_result_t;

    // Shifted out MSB first
    typedef struct packed {
        logic [`SAP_DATA_W-1:0] a;
        logic [`SAP_DATA_W-1:0] b;
        logic [`SAP_DATA_W-1:0] acc;
        logic [`SAP_DATA_W-1:0] pc;
        logic                   song_valid;
        logic [3:0]             song;
        logic [2:0]             step;
    } spi_frame_t;

endpackage

/* rtl/program_ram.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module program_ram (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req0,
    input  logic [`SAP_ADDR_W-1:0] addr0,
    input  logic                   we0,
    input  cpu_pkg::mem_word_u     wdata0,
    output logic                   ack0,
    output cpu_pkg::mem_word_u     rdata0,
    input  logic                   req1,
    input  logic [`SAP_ADDR_W-1:0] addr1,
    input  logic                   we1,
    input  cpu_pkg::mem_word_u     wdata1,
    output logic                   ack1,
    output cpu_pkg::mem_word_u     rdata1
);
    cpu_pkg::mem_word_u mem [`SAP_MEM_DEPTH];
    cpu_pkg::mem_word_u rd_q;
    logic busy;
    logic sel;   // Granted port
    logic serve; // Access cycle one after the grant

    assign serve = busy && !(sel ? ack1 : ack0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            sel  <= 1'b0;
            ack0 <= 1'b0;
            ack1 <= 1'b0;
        end else if (!busy) begin
            if (req0 || req1) begin
                busy <= 1'b1;
                sel  <= !req0; // Loader wins ties
            end
        end else if (serve) begin
            ack0 <= !sel;
            ack1 <= sel;
        end else if (!(sel ? req1 : req0)) begin
            ack0 <= 1'b0;
            ack1 <= 1'b0;
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            if (sel ? we1 : we0)
                mem[sel ? addr1 : addr0] <= sel ? wdata1 : wdata0;
            rd_q <= mem[sel ? addr1 : addr0];
        end
    end

    assign rdata0 = rd_q;
    assign rdata1 = rd_q;

    single_ack: assert property (@(posedge clk) disable iff (reset) !(ack0 && ack1));
endmodule

/* rtl/program_loader.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module program_loader (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run_req,
    input  io_pkg::host_cmd_t      cmd,
    input  logic                   frame_done,
    output logic                   run_ack,
    output logic                   run,
    output logic                   mem_req,
    output logic [`SAP_ADDR_W-1:0] mem_addr,
    output cpu_pkg::mem_word_u     mem_wdata,
    input  logic                   mem_ack
);
    typedef enum logic [1:0] {L_IDLE, L_REQ, L_DROP, L_RUN} load_state_e;

    load_state_e state;
    io_pkg::host_cmd_t cmd_q;
    logic [2:0] idx;
    logic last;

    function automatic cpu_pkg::mem_word_u op_word(cpu_pkg::opcode_e op, int arg);
        cpu_pkg::mem_word_u w;
        w.instr.opcode  = op;
        w.instr.operand = `SAP_ADDR_W'(arg);
        return w;
    endfunction

    // Word list in address order
    always_comb begin
        mem_addr = `SAP_ADDR_W'(idx);
        last     = (idx == 3'd6);
        case (idx)
            3'd0: mem_wdata = op_word(cpu_pkg::OP_LDA, `SAP_ADDR_A);
            3'd1: mem_wdata = op_word((cmd_q.prog_sel == io_pkg::PROG_SUB) ?
                                      cpu_pkg::OP_SUB : cpu_pkg::OP_ADD, `SAP_ADDR_B);
            3'd2: mem_wdata = op_word(cpu_pkg::OP_OUT, 0);
            3'd3: mem_wdata = op_word(cpu_pkg::OP_SNG, 0);
            3'd4: mem_wdata = op_word(cpu_pkg::OP_HLT, 0);
            3'd5: begin
                mem_addr       = `SAP_ADDR_W'(`SAP_ADDR_B);
                mem_wdata.data = cmd_q.operand_b;
            end
            default: begin
                mem_addr       = `SAP_ADDR_W'(`SAP_ADDR_A);
                mem_wdata.data = cmd_q.operand_a;
            end
        endcase
        if (cmd_q.prog_sel == io_pkg::PROG_SNG) begin
            last      = (idx == 3'd1);
            mem_wdata = (idx == 3'd0) ? op_word(cpu_pkg::OP_SNG, cmd_q.song)
                                      : op_word(cpu_pkg::OP_HLT, 0);
        end
    end

    always_ff @(posedge clk) begin
        if (state == L_IDLE && run_req)
            cmd_q <= cmd;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= L_IDLE;
            idx     <= '0;
            run_ack <= 1'b0;
        end else begin
            case (state)
                L_IDLE: if (run_req) begin
                    idx   <= '0;
                    state <= L_REQ;
                end
                L_REQ: if (mem_ack) state <= L_DROP;
                L_DROP: if (!mem_ack) begin
                    idx   <= idx + 3'd1;
                    state <= last ? L_RUN : L_REQ;
                end
                default: begin
                    run_ack <= frame_done;
                    if (!run_req) begin
                        run_ack <= 1'b0;
                        state   <= L_IDLE;
                    end
                end
            endcase
        end
    end

    assign mem_req = (state == L_REQ);
    assign run     = (state == L_RUN);

    req_held_to_ack: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req);
endmodule

/* cpu/sap_controller.sv */
`timescale 1ns/100ps

module sap_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  cpu_pkg::instr_t     ir,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                clear_regs,
    output logic                halted,
    output cpu_pkg::step_t      step,
    output logic                mem_req,
    input  logic                mem_ack
);
    typedef enum logic [1:0] {M_IDLE, M_REQ, M_DROP} mem_state_e;

    mem_state_e m_state;
    logic run_q;
    logic active;
    logic mem_step;
    logic mem_strobe;
    logic hlt_now;
    logic advance;

    assign clear_regs = run & ~run_q;
    assign active     = run & run_q & ~halted;
    assign hlt_now    = (step == cpu_pkg::T3) && (ir.opcode == cpu_pkg::OP_HLT);
    assign mem_step   = (step == cpu_pkg::T2) || ((step == cpu_pkg::T4) &&
                        (ir.opcode inside {cpu_pkg::OP_LDA, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB}));
    assign mem_req    = (m_state == M_REQ);
    assign mem_strobe = (m_state == M_REQ) && mem_ack; // rdata valid this cycle
    // Memory steps move on once ack has fallen again
    assign advance    = active && !hlt_now && (!mem_step || (m_state == M_DROP && !mem_ack));

    always_comb begin
        ctrl = '0;
        if (active) begin
            case (step)
                cpu_pkg::T0: begin
                    ctrl.pc_en    = 1'b1;
                    ctrl.mar_load = 1'b1;
                end
                cpu_pkg::T1: ctrl.pc_inc = 1'b1;
                cpu_pkg::T2: begin
                    ctrl.mem_en  = mem_strobe;
                    ctrl.ir_load = mem_strobe;
                end
                cpu_pkg::T3: begin
                    case (ir.opcode)
                        cpu_pkg::OP_LDA, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
                            ctrl.ir_en    = 1'b1;
                            ctrl.mar_load = 1'b1;
                        end
                        cpu_pkg::OP_SNG: ctrl.sng_en   = 1'b1;
                        cpu_pkg::OP_OUT: ctrl.out_load = 1'b1;
                        default: ;
                    endcase
                end
                cpu_pkg::T4: begin
                    ctrl.mem_en = mem_strobe;
                    ctrl.a_load = mem_strobe && (ir.opcode == cpu_pkg::OP_LDA);
                    ctrl.b_load = mem_strobe && (ir.opcode != cpu_pkg::OP_LDA);
                end
                cpu_pkg::T5: begin
                    ctrl.alu_en   = (ir.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB});
                    ctrl.acc_load = ctrl.alu_en;
                    ctrl.alu_sub  = (ir.opcode == cpu_pkg::OP_SUB);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_q   <= 1'b0;
            step    <= cpu_pkg::T0;
            halted  <= 1'b0;
            m_state <= M_IDLE;
        end else begin
            run_q <= run;
            if (!run) begin
                step    <= cpu_pkg::T0;
                halted  <= 1'b0;
                m_state <= M_IDLE;
            end else begin
                if (active && hlt_now)
                    halted <= 1'b1; // Step stays at T3
                if (advance)
                    step <= (step == cpu_pkg::T5) ? cpu_pkg::T0 : cpu_pkg::step_t'(step + 3'd1);
                case (m_state)
                    M_IDLE:  if (active && mem_step) m_state <= M_REQ;
                    M_REQ:   if (mem_ack) m_state <= M_DROP;
                    default: if (!mem_ack) m_state <= M_IDLE;
                endcase
            end
        end
    end

    step_in_range: assert property (@(posedge clk) disable iff (reset) step <= cpu_pkg::T5);
endmodule

/* cpu/sap_datapath.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module sap_datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::ctrl_word_t    ctrl,
    input  logic                   clear_regs,
    input  cpu_pkg::mem_word_u     mem_rdata,
    output logic [`SAP_ADDR_W-1:0] mem_addr,
    output cpu_pkg::instr_t        ir,
    output io_pkg::run_result_t    result,
    output io_pkg::spi_frame_t     frame,
    input  cpu_pkg::step_t         step
);
    logic [`SAP_ADDR_W-1:0] pc;
    logic [`SAP_ADDR_W-1:0] mar;
    logic [`SAP_DATA_W-1:0] a;
    logic [`SAP_DATA_W-1:0] b;
    logic [`SAP_DATA_W-1:0] acc;
    logic [`SAP_DATA_W-1:0] alu_val;
    logic [`SAP_DATA_W:0]   sum;
    logic [3:0] song;
    logic song_valid;
    logic ovf;
    logic unf;
    logic alu_ovf;
    logic alu_unf;
    cpu_pkg::mem_word_u bus;

    always_comb begin
        bus.data = '0;
        if (ctrl.mem_en)
            bus = mem_rdata;
        else if (ctrl.pc_en)
            bus.data = `SAP_DATA_W'(pc);
        else if (ctrl.ir_en)
            bus.data = `SAP_DATA_W'(ir.operand);
        else if (ctrl.alu_en)
            bus.data = alu_val;
    end

    // Saturating adder/subtractor
    always_comb begin
        sum     = {1'b0, a} + {1'b0, b};
        alu_ovf = 1'b0;
        alu_unf = 1'b0;
        if (ctrl.alu_sub) begin
            alu_unf = (a < b);
            alu_val = alu_unf ? '0 : a - b;
        end else begin
            alu_ovf = sum[`SAP_DATA_W];
            alu_val = alu_ovf ? '1 : sum[`SAP_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= '0;
            song_valid <= 1'b0;
        end else if (clear_regs) begin
            pc         <= '0;
            song_valid <= 1'b0;
        end else begin
            if (ctrl.pc_inc) pc <= pc + 1'b1;
            if (ctrl.sng_en) song_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_regs) begin
            mar  <= '0;
            ir   <= '0;
            a    <= '0;
            b    <= '0;
            acc  <= '0;
            ovf  <= 1'b0;
            unf  <= 1'b0;
            song <= '0;
            result <= '0;
        end else begin
            if (ctrl.mar_load) mar <= bus.data[`SAP_ADDR_W-1:0];
            if (ctrl.ir_load) ir <= bus.instr;
            if (ctrl.a_load) a <= bus.data;
            if (ctrl.b_load) b <= bus.data;
            if (ctrl.acc_load) begin
                acc <= bus.data;
                ovf <= alu_ovf;
                unf <= alu_unf;
            end
            if (ctrl.sng_en) song <= ir.operand;
            if (ctrl.out_load) result <= '{value: acc, overflow: ovf, underflow: unf};
        end
    end

    assign mem_addr = mar;
    assign frame = '{a: a, b: b, acc: acc, pc: `SAP_DATA_W'(pc), song_valid: song_valid,
                     song: song, step: step};

    one_bus_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.pc_en, ctrl.mem_en, ctrl.ir_en, ctrl.alu_en}));
endmodule

/* rtl/spi_status_tx.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module spi_status_tx (
    input  logic               clk,
    input  logic               reset,
    input  logic               halted,
    input  logic               run,
    input  io_pkg::spi_frame_t frame,
    output logic               sclk,
    output logic               mosi,
    output logic               cs_n,
    output logic               frame_done
);
    localparam int DIV_W = $clog2(`SAP_SPI_CLK_DIV);
    localparam int BIT_W = $clog2(`SAP_SPI_FRAME_W);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_DONE} spi_state_e;

    spi_state_e state;
    logic [`SAP_SPI_FRAME_W-1:0] shreg;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic halted_q;
    logic start;
    logic fall; // sclk about to go low

    assign start = (state == S_IDLE) && halted && !halted_q;
    assign fall  = (state == S_SHIFT) && sclk && (div_cnt == DIV_W'(`SAP_SPI_CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (start)
            shreg <= frame;
        else if (fall)
            shreg <= shreg << 1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            halted_q   <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            sclk       <= 1'b0;
            mosi       <= 1'b0;
            cs_n       <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            halted_q <= halted;
            case (state)
                S_IDLE: if (start) begin
                    cs_n    <= 1'b0;
                    mosi    <= frame[`SAP_SPI_FRAME_W-1];
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == DIV_W'(`SAP_SPI_CLK_DIV - 1)) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                    end
                    if (fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi    <= shreg[`SAP_SPI_FRAME_W-2];
                        if (bit_cnt == BIT_W'(`SAP_SPI_FRAME_W - 1)) begin
                            mosi       <= 1'b0;
                            cs_n       <= 1'b1;
                            frame_done <= 1'b1;
                            state      <= S_DONE;
                        end
                    end
                end
                default: if (!run) begin
                    frame_done <= 1'b0;
                    state      <= S_IDLE;
                end
            endcase
        end
    end
endmodule

/* rtl/sap_top.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module sap_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                run_req,
    input  io_pkg::host_cmd_t   cmd,
    output logic                run_ack,
    output io_pkg::run_result_t result,
    output logic                sclk,
    output logic                mosi,
    output logic                cs_n
);
    logic run;
    logic frame_done;
    logic halted;
    logic clear_regs;
    logic ld_req;
    logic ld_ack;
    logic cpu_req;
    logic cpu_ack;
    logic [`SAP_ADDR_W-1:0] ld_addr;
    logic [`SAP_ADDR_W-1:0] cpu_addr;
    cpu_pkg::mem_word_u ld_wdata;
    cpu_pkg::mem_word_u cpu_rdata;
    cpu_pkg::instr_t ir;
    cpu_pkg::ctrl_word_t ctrl;
    cpu_pkg::step_t step;
    io_pkg::spi_frame_t frame;

    program_loader loader_i (
        .clk(clk), .reset(reset), .run_req(run_req), .cmd(cmd), .frame_done(frame_done),
        .run_ack(run_ack), .run(run), .mem_req(ld_req), .mem_addr(ld_addr),
        .mem_wdata(ld_wdata), .mem_ack(ld_ack)
    );

    // Port 0 only writes, port 1 only reads
    program_ram ram_i (
        .clk(clk), .reset(reset),
        .req0(ld_req), .addr0(ld_addr), .we0(1'b1), .wdata0(ld_wdata),
        .ack0(ld_ack), .rdata0(),
        .req1(cpu_req), .addr1(cpu_addr), .we1(1'b0), .wdata1('0),
        .ack1(cpu_ack), .rdata1(cpu_rdata)
    );

    sap_controller ctrl_i (
        .clk(clk), .reset(reset), .run(run), .ir(ir), .ctrl(ctrl), .clear_regs(clear_regs),
        .halted(halted), .step(step), .mem_req(cpu_req), .mem_ack(cpu_ack)
    );

    sap_datapath dp_i (
        .clk(clk), .reset(reset), .ctrl(ctrl), .clear_regs(clear_regs), .mem_rdata(cpu_rdata),
        .mem_addr(cpu_addr), .ir(ir), .result(result), .frame(frame), .step(step)
    );

    spi_status_tx spi_i (
        .clk(clk), .reset(reset), .halted(halted), .run(run), .frame(frame),
        .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .frame_done(frame_done)
    );
endmodule

/* sim/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Saturating add and subtract of the run result
function automatic io_pkg::run_result_t model_result(input io_pkg::prog_sel_e sel,
                                                    input logic [`SAP_DATA_W-1:0] a,
                                                    input logic [`SAP_DATA_W-1:0] b);
    io_pkg::run_result_t r;
    int full;
    r = '0;
    if (sel == io_pkg::PROG_SUB) begin
        if (a < b)
            r.underflow = 1'b1;
        else
            r.value = a - b;
    end else begin
        full = int'(a) + int'(b);
        if (full > 255) begin
            r.value    = 8'hFF;
            r.overflow = 1'b1;
        end else begin
            r.value = 8'(full);
        end
    end
    return r;
endfunction

task automatic check_result(input io_pkg::run_result_t got, input io_pkg::run_result_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: result got %h expected %h", got, exp);
    end
endtask

task automatic check_frame(input io_pkg::spi_frame_t got, input io_pkg::spi_frame_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: spi frame got %h expected %h", got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("** Error: %s got %h expected %h", name, got, exp);
    end
endtask

task automatic wait_ack(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (run_ack !== level && cycles < ACK_WAIT_CYCLES) begin
        @(negedge clk);
        cycles++;
    end
    if (run_ack !== level) begin
        other_errors++;
        $display("run_ack did not %s within %0d cycles", what, ACK_WAIT_CYCLES);
    end
endtask

// Raise run_req and wait for the halted run and its frame
task automatic start_run(input io_pkg::host_cmd_t c);
    int bits_before;
    int frames_before;
    bits_before   = rx_bits;
    frames_before = frames_started;
    @(posedge clk);
    cmd     <= c;
    run_req <= 1'b1;
    wait_ack(1'b1, "rise");
    if (rx_bits - bits_before != `SAP_SPI_FRAME_W) begin
        other_errors++;
        $display("SPI receiver got %0d bits instead of one full frame",
                 rx_bits - bits_before);
    end
    if (frames_started - frames_before != 1) begin
        other_errors++;
        $display("Expected one SPI frame per run, saw %0d", frames_started - frames_before);
    end
    check_bit("cs_n", cs_n, 1'b1);
endtask

task automatic finish_run();
    @(posedge clk);
    run_req <= 1'b0;
    wait_ack(1'b0, "fall");
endtask

task automatic run_alu(input io_pkg::prog_sel_e sel, input logic [`SAP_DATA_W-1:0] a,
                       input logic [`SAP_DATA_W-1:0] b);
    io_pkg::host_cmd_t c;
    io_pkg::run_result_t exp;
    io_pkg::spi_frame_t exp_frame;
    c   = '{prog_sel: sel, operand_a: a, operand_b: b, song: 4'h0};
    exp = model_result(sel, a, b);
    // PC ends at 5 after fetching up to HLT
    exp_frame = '{a: a, b: b, acc: exp.value, pc: 8'd5, song_valid: 1'b1,
                  song: 4'h0, step: 3'd3};
    start_run(c);
    check_result(result, exp);
    check_frame(io_pkg::spi_frame_t'(rx_shift), exp_frame);
    finish_run();
endtask

task automatic test_reset_state();
    @(negedge clk);
    check_bit("run_ack", run_ack, 1'b0);
    check_bit("cs_n", cs_n, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
endtask

task automatic test_add();
    logic [`SAP_DATA_W-1:0] a;
    logic [`SAP_DATA_W-1:0] b;
    a = 8'($urandom_range(0, 255));
    b = 8'($urandom_range(0, 255 - a)); // No carry
    run_alu(io_pkg::PROG_ADD, a, b);
endtask

task automatic test_add_saturation();
    logic [`SAP_DATA_W-1:0] a;
    logic [`SAP_DATA_W-1:0] b;
    a = 8'($urandom_range(1, 255));
    b = 8'($urandom_range(256 - a, 255));
    run_alu(io_pkg::PROG_ADD, a, b);
endtask

task automatic test_sub();
    logic [`SAP_DATA_W-1:0] a;
    logic [`SAP_DATA_W-1:0] b;
    a = 8'($urandom_range(0, 255));
    b = 8'($urandom_range(0, a));
    run_alu(io_pkg::PROG_SUB, a, b);
    a = 8'($urandom_range(0, 254));
    b = 8'($urandom_range(a + 1, 255)); // Underflow case
    run_alu(io_pkg::PROG_SUB, a, b);
endtask

task automatic test_sng();
    io_pkg::host_cmd_t c;
    io_pkg::spi_frame_t exp_frame;
    logic [3:0] song;
    song      = 4'($urandom_range(0, 15));
    c         = '{prog_sel: io_pkg::PROG_SNG, operand_a: 8'h00, operand_b: 8'h00, song: song};
    exp_frame = '{a: 8'h00, b: 8'h00, acc: 8'h00, pc: 8'd2, song_valid: 1'b1,
                  song: song, step: 3'd3};
    start_run(c);
    check_frame(io_pkg::spi_frame_t'(rx_shift), exp_frame);
    finish_run();
endtask

task automatic test_back_pressure();
    io_pkg::host_cmd_t c;
    io_pkg::run_result_t exp;
    logic [`SAP_DATA_W-1:0] a;
    logic [`SAP_DATA_W-1:0] b;
    int frames_before;
    a   = 8'($urandom_range(0, 255));
    b   = 8'($urandom_range(0, 255));
    c   = '{prog_sel: io_pkg::PROG_ADD, operand_a: a, operand_b: b, song: 4'h0};
    exp = model_result(io_pkg::PROG_ADD, a, b);
    start_run(c);
    check_result(result, exp);
    frames_before = frames_started;
    repeat (HOLD_CYCLES) begin
        @(negedge clk);
        check_bit("run_ack", run_ack, 1'b1);
        check_bit("cs_n", cs_n, 1'b1);
        check_result(result, exp);
    end
    if (frames_started != frames_before) begin
        other_errors++;
        $display("A second SPI frame started while run_req was held high");
    end
    finish_run();
    // The next run must work normally
    run_alu(io_pkg::PROG_SUB, 8'($urandom_range(128, 255)), 8'($urandom_range(0, 127)));
endtask

`endif

/* sim/tb_sap_top.sv */
`timescale 1ns/100ps
`include "sap_macros.svh"

module tb_sap_top;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_COUNT       = 7;     // Runs started by the test sequence
    localparam int RUN_TIME_NS     = 20000;
    localparam int ACK_WAIT_CYCLES = 1000;
    localparam int HOLD_CYCLES     = 100;

    logic clk;
    logic reset;
    logic run_req;
    io_pkg::host_cmd_t cmd;
    logic run_ack;
    io_pkg::run_result_t result;
    logic sclk;
    logic mosi;
    logic cs_n;

    logic [`SAP_SPI_FRAME_W-1:0] rx_shift = '0;
    int rx_bits        = 0;
    int frames_started = 0;
    int value_errors   = 0;
    int other_errors   = 0;

    sap_top sap_top_i (
        .clk(clk),
        .reset(reset),
        .run_req(run_req),
        .cmd(cmd),
        .run_ack(run_ack),
        .result(result),
        .sclk(sclk),
        .mosi(mosi),
        .cs_n(cs_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // SPI receiver shifting in MSB first
    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_shift <= {rx_shift[`SAP_SPI_FRAME_W-2:0], mosi};
            rx_bits  <= rx_bits + 1;
        end
    end

    always @(negedge cs_n) frames_started <= frames_started + 1;

    `include "tb_tasks.svh"

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        run_req = 1'b0;
        cmd     = '0;
        void'($urandom(32'h35f7));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_add();
        test_add_saturation();
        test_sub();
        test_sng();
        test_back_pressure();

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(RESET_CYCLES * CLK_PERIOD + RUN_COUNT * RUN_TIME_NS + HOLD_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("sim failed");
        $finish;
    end
endmodule

/* files.f */
+incdir+common
+incdir+sim
common/cpu_pkg.sv
common/io_pkg.sv
rtl/program_ram.sv
rtl/program_loader.sv
cpu/sap_controller.sv
cpu/sap_datapath.sv
rtl/spi_status_tx.sv
rtl/sap_top.sv
sim/tb_sap_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and search the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sap_top -f files.f &&
./obj_dir/Vtb_sap_top | tee /dev/stderr | grep -x "sim passed" > /dev/null ||
{ echo "Run did not pass" >&2; exit 1; }
